// File: bmm_assertions.sv
// Bound checks of the block matrix multiplier
// Wishbone handshake, engine latency and status bit exclusion

`include "bmm_defines.svh"

module bmm_assertions (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic issue,
    input logic res_valid,
    input logic busy,
    input logic done
);

    timeunit 1ns;
    timeprecision 1ps;

    // Single-cycle acknowledge
    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack high for two cycles");

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> (wb_cyc && wb_stb))
        else $error("wb_ack rose outside a bus cycle");

    // One latch cycle, then one cycle per step of k
    engine_latency: assert property (@(posedge clk) disable iff (rst)
        issue |-> ##(`BMM_SIZE + 1) res_valid)
        else $error("res_valid did not follow issue on time");

    busy_done_excl: assert property (@(posedge clk) disable iff (rst) !(busy && done))
        else $error("busy and done high together");

endmodule

bind bmm_top bmm_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .issue     (blk_bus.issue),
    .res_valid (blk_bus.res_valid),
    .busy      (busy),
    .done      (done)
);

// File: bmm_block_sched.sv
// Block scheduler of the block multiplier
// Walks the block positions of C in row-major order, one block in flight,
// and writes each block result back before issuing the next

`include "bmm_defines.svh"

module bmm_block_sched import bmm_types_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  start,
    output logic  busy,
    output logic  done,
    block_if.ctrl blk
);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT,
        WRITE
    } state_t;

    localparam blk_idx_t LAST_POS = blk_idx_t'(`BMM_NBLK - 1);

    state_t   state;
    blk_idx_t row;
    blk_idx_t col;
    logic     last_blk;

    assign last_blk = (row == LAST_POS) && (col == LAST_POS);

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            row   <= '0;
            col   <= '0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            case (state)
                // Start is only seen here, so a start while busy is dropped
                IDLE: begin
                    if (start) begin
                        busy  <= 1'b1;
                        done  <= 1'b0;
                        row   <= '0;
                        col   <= '0;
                        state <= ISSUE;
                    end
                end
                ISSUE: state <= WAIT;
                WAIT: begin
                    if (blk.res_valid) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    if (last_blk) begin
                        busy  <= 1'b0;
                        done  <= 1'b1;
                        state <= IDLE;
                    end else begin
                        // Step row-major to the next block
                        if (col == LAST_POS) begin
                            col <= '0;
                            row <= row + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                        state <= ISSUE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign blk.blk_row = row;
    assign blk.blk_col = col;
    assign blk.issue   = (state == ISSUE);
    assign blk.res_we  = (state == WRITE);
    assign blk.busy    = busy;

endmodule

// File: bmm_bus_pkg.sv
// Bus side types of the block multiplier
// Register word views and the decoded address regions

`include "bmm_defines.svh"

package bmm_bus_pkg;

    import bmm_types_pkg::*;

    // Packed elements of one A or B word, lowest element in bits 3:0
    typedef elem_t [`BMM_EPW-1:0] elem_word_t;

    // Control and status layout of word 0
    typedef struct packed {
        logic [`BMM_WORD_W-4:0] rsvd;
        logic                   done;
        logic                   busy;
        logic                   start;
    } ctrl_word_t;

    // One bus word seen either as matrix elements or as the control word
    typedef union packed {
        elem_word_t elems;
        ctrl_word_t ctrl;
    } reg_word_u;

    // Region hit by a word address
    typedef enum logic [2:0] {
        CTRL,
        MAT_A,
        MAT_B,
        MAT_C,
        NONE
    } region_e;

    // Word offset for A and B, element offset for C
    typedef logic [$clog2(`BMM_SIZE * `BMM_SIZE)-1:0] store_idx_t;

endpackage

// File: bmm_defines.svh
// Block matrix multiplier configuration
// Arithmetic widths, matrix and block geometry, Wishbone word map

`ifndef BMM_DEFINES_SVH
`define BMM_DEFINES_SVH

// Arithmetic widths
`define BMM_DATA_W 4
`define BMM_ACC_W 10

// Matrix geometry
`define BMM_SIZE 4
`define BMM_BLOCK 2
`define BMM_NBLK (`BMM_SIZE / `BMM_BLOCK)

// Bus word, elements per word and words per matrix
`define BMM_WORD_W 32
`define BMM_EPW (`BMM_WORD_W / `BMM_DATA_W)
`define BMM_MAT_WORDS ((`BMM_SIZE * `BMM_SIZE) / `BMM_EPW)

// Word address map
`define BMM_ADR_W 5
`define BMM_ADR_CTRL 0
`define BMM_ADR_A 1
`define BMM_ADR_B 3
`define BMM_ADR_C 16

`endif

// File: bmm_ifs.sv
// Internal interfaces of the block multiplier
// store_if carries host accesses into the matrix store
// block_if links the block scheduler, the matrix store and the block engine

`include "bmm_defines.svh"

interface store_if import bmm_bus_pkg::*; ();

    logic                   wr;
    logic                   rd;
    region_e                region;
    store_idx_t             index;
    elem_word_t             wdata;
    logic [`BMM_WORD_W-1:0] rdata;

    modport host (output wr, rd, region, index, wdata,
                  input  rdata);

    modport mem (input  wr, rd, region, index, wdata,
                 output rdata);

endinterface

interface block_if import bmm_types_pkg::*; ();

    // Scheduler side
    blk_idx_t    blk_row;
    blk_idx_t    blk_col;
    logic        issue;
    logic        res_we;
    logic        busy;

    // Operands picked out by the store
    row_bundle_t a_rows;
    col_bundle_t b_cols;

    // Engine result
    logic        res_valid;
    block_res_t  res;

    modport ctrl (output blk_row, blk_col, issue, res_we, busy,
                  input  res_valid);

    modport mem (input  blk_row, blk_col, res_we, busy, res,
                 output a_rows, b_cols);

    modport engine (input  issue, a_rows, b_cols,
                    output res_valid, res);

endinterface

// File: bmm_matrix_store.sv
// Matrix store of the block multiplier
// Holds A, B and C, serves host reads and writes, selects the operand
// rows and columns of the current block and writes block results into C

`include "bmm_defines.svh"

module bmm_matrix_store import bmm_types_pkg::*, bmm_bus_pkg::*; (
    input logic  clk,
    input logic  rst,
    store_if.mem acc,
    block_if.mem blk
);

    // Whole matrix rows carried by one bus word
    localparam int ROWS_PER_WORD = `BMM_EPW / `BMM_SIZE;

    elem_t      mat_a [`BMM_SIZE][`BMM_SIZE];
    elem_t      mat_b [`BMM_SIZE][`BMM_SIZE];
    acc_t       mat_c [`BMM_SIZE][`BMM_SIZE];
    elem_word_t rd_elems;
    logic       host_wr;

    // A and B stay frozen while a product is running
    assign host_wr = acc.wr && !blk.busy;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < `BMM_SIZE; r++) begin
                for (int c = 0; c < `BMM_SIZE; c++) begin
                    mat_a[r][c] <= '0;
                    mat_b[r][c] <= '0;
                    mat_c[r][c] <= '0;
                end
            end
        end else begin
            if (host_wr && acc.region == MAT_A) begin
                for (int r = 0; r < ROWS_PER_WORD; r++) begin
                    for (int c = 0; c < `BMM_SIZE; c++) begin
                        mat_a[acc.index * ROWS_PER_WORD + r][c] <= acc.wdata[r * `BMM_SIZE + c];
                    end
                end
            end
            if (host_wr && acc.region == MAT_B) begin
                for (int r = 0; r < ROWS_PER_WORD; r++) begin
                    for (int c = 0; c < `BMM_SIZE; c++) begin
                        mat_b[acc.index * ROWS_PER_WORD + r][c] <= acc.wdata[r * `BMM_SIZE + c];
                    end
                end
            end
            // Block result lands at its block row and column
            if (blk.res_we) begin
                for (int i = 0; i < `BMM_BLOCK; i++) begin
                    for (int j = 0; j < `BMM_BLOCK; j++) begin
                        mat_c[blk.blk_row * `BMM_BLOCK + i][blk.blk_col * `BMM_BLOCK + j]
                            <= blk.res[i][j];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Host read path
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int r = 0; r < ROWS_PER_WORD; r++) begin
            for (int c = 0; c < `BMM_SIZE; c++) begin
                if (acc.region == MAT_B) begin
                    rd_elems[r * `BMM_SIZE + c] = mat_b[acc.index * ROWS_PER_WORD + r][c];
                end else begin
                    rd_elems[r * `BMM_SIZE + c] = mat_a[acc.index * ROWS_PER_WORD + r][c];
                end
            end
        end
    end

    always_comb begin
        acc.rdata = '0;
        if (acc.rd) begin
            case (acc.region)
                MAT_A, MAT_B: acc.rdata = rd_elems;
                MAT_C:        acc.rdata[`BMM_ACC_W-1:0] = mat_c[acc.index / `BMM_SIZE]
                                                               [acc.index % `BMM_SIZE];
                default:      acc.rdata = '0;
            endcase
        end
    end

    // Operand selection for the engine
    always_comb begin
        for (int i = 0; i < `BMM_BLOCK; i++) begin
            for (int k = 0; k < `BMM_SIZE; k++) begin
                blk.a_rows[i][k] = mat_a[blk.blk_row * `BMM_BLOCK + i][k];
                blk.b_cols[k][i] = mat_b[k][blk.blk_col * `BMM_BLOCK + i];
            end
        end
    end

endmodule

// File: bmm_partial.sv
// Block engine of the block multiplier
// Computes one BLOCK x BLOCK block of C with one multiply-accumulate lane
// per result element, stepping k over the shared dimension once per cycle

`include "bmm_defines.svh"

module bmm_partial import bmm_types_pkg::*; (
    input logic     clk,
    input logic     rst,
    block_if.engine blk
);

    localparam k_idx_t LAST_K = k_idx_t'(`BMM_SIZE - 1);

    row_bundle_t a_q;
    col_bundle_t b_q;
    block_res_t  sum_q;
    k_idx_t      k;
    logic        running;

    ////////////////////////////////////////////////////////////
    // Step control
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running       <= 1'b0;
            k             <= '0;
            blk.res_valid <= 1'b0;
        end else begin
            blk.res_valid <= 1'b0;
            if (blk.issue) begin
                running <= 1'b1;
                k       <= '0;
            end else if (running) begin
                k <= k + 1'b1;
                // Last product enters the sums this cycle
                if (k == LAST_K) begin
                    running       <= 1'b0;
                    blk.res_valid <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Multiply-accumulate lanes
    ////////////////////////////////////////////////////////////

    // Operands latched on issue, sums cleared with them
    always_ff @(posedge clk) begin
        if (blk.issue) begin
            a_q   <= blk.a_rows;
            b_q   <= blk.b_cols;
            sum_q <= '0;
        end else if (running) begin
            for (int i = 0; i < `BMM_BLOCK; i++) begin
                for (int j = 0; j < `BMM_BLOCK; j++) begin
                    sum_q[i][j] <= sum_q[i][j] + acc_t'(a_q[i][k]) * acc_t'(b_q[k][j]);
                end
            end
        end
    end

    // Sums hold until the next issue
    assign blk.res = sum_q;

endmodule

// File: bmm_tb.sv
// Testbench of the block matrix multiplier
// Directed tests over the Wishbone port, checked against a software reference

`include "bmm_defines.svh"

module bmm_tb import bmm_types_pkg::*, bmm_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RPW        = `BMM_EPW / `BMM_SIZE;
    localparam int NUM_TESTS  = 6;
    // Roughly 300 cycles per test, doubled, plus reset and slack
    localparam int MAX_CYCLES = NUM_TESTS * 300 * 2 + 400;

    logic                   clk;
    logic                   rst;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`BMM_ADR_W-1:0]  wb_adr;
    logic [`BMM_WORD_W-1:0] wb_dat_w;
    logic [`BMM_WORD_W-1:0] wb_dat_r;
    logic                   wb_ack;

    elem_t       a_m   [`BMM_SIZE][`BMM_SIZE];
    elem_t       b_m   [`BMM_SIZE][`BMM_SIZE];
    acc_t        c_exp [`BMM_SIZE][`BMM_SIZE];
    logic [31:0] rng_state = 32'h4f6a_5582;
    int          cycles    = 0;
    int          checks    = 0;
    int          errors    = 0;
    int          err_mark  = 0;

    bmm_top DUT (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus access and stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic bus_cycle(input logic we, input logic [`BMM_ADR_W-1:0] adr,
                             input logic [`BMM_WORD_W-1:0] wdata,
                             output logic [`BMM_WORD_W-1:0] rdata);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!wb_ack && waited < 8);
        rdata = wb_dat_r;
        if (!wb_ack) begin
            errors++;
            $display("Access to address %0d was not acknowledged within 8 cycles", adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [`BMM_ADR_W-1:0] adr, input logic [`BMM_WORD_W-1:0] data);
        logic [`BMM_WORD_W-1:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [`BMM_ADR_W-1:0] adr, output logic [`BMM_WORD_W-1:0] data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic reg_word_u status_word(input logic busy, input logic done);
        reg_word_u w;
        w           = '0;
        w.ctrl.busy = busy;
        w.ctrl.done = done;
        return w;
    endfunction

    task automatic fill_random();
        for (int r = 0; r < `BMM_SIZE; r++) begin
            for (int c = 0; c < `BMM_SIZE; c++) begin
                a_m[r][c] = elem_t'(next_rand());
                b_m[r][c] = elem_t'(next_rand());
            end
        end
    endtask

    // Reference product, plain integer sum over the shared dimension
    task automatic compute_reference();
        int sum;
        for (int i = 0; i < `BMM_SIZE; i++) begin
            for (int j = 0; j < `BMM_SIZE; j++) begin
                sum = 0;
                for (int k = 0; k < `BMM_SIZE; k++) begin
                    sum = sum + int'(a_m[i][k]) * int'(b_m[k][j]);
                end
                c_exp[i][j] = acc_t'(sum);
            end
        end
    endtask

    task automatic load_matrices();
        reg_word_u word_a;
        reg_word_u word_b;
        for (int w = 0; w < `BMM_MAT_WORDS; w++) begin
            for (int e = 0; e < `BMM_EPW; e++) begin
                word_a.elems[e] = a_m[w * RPW + e / `BMM_SIZE][e % `BMM_SIZE];
                word_b.elems[e] = b_m[w * RPW + e / `BMM_SIZE][e % `BMM_SIZE];
            end
            wb_write(`BMM_ADR_A + w, word_a);
            wb_write(`BMM_ADR_B + w, word_b);
        end
    endtask

    task automatic start_product();
        reg_word_u cmd;
        cmd            = '0;
        cmd.ctrl.start = 1'b1;
        wb_write(`BMM_ADR_CTRL, cmd);
    endtask

    task automatic wait_done();
        reg_word_u stat;
        int        polls;
        stat  = '0;
        polls = 0;
        while (!stat.ctrl.done && polls < 100) begin
            wb_read(`BMM_ADR_CTRL, stat);
            polls++;
        end
        if (!stat.ctrl.done) begin
            errors++;
            $display("Done bit still low after %0d status reads", polls);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_acc(input string name, input acc_t got, input acc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0d ns %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input reg_word_u got, input reg_word_u exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] t=%0d ns %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_result();
        logic [`BMM_WORD_W-1:0] data;
        for (int i = 0; i < `BMM_SIZE; i++) begin
            for (int j = 0; j < `BMM_SIZE; j++) begin
                wb_read(`BMM_ADR_C + i * `BMM_SIZE + j, data);
                check_acc($sformatf("C[%0d][%0d]", i, j), acc_t'(data), c_exp[i][j]);
            end
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %-20s %s, %0d errors", name,
                 (errors == err_mark) ? "ok" : "failed", errors - err_mark);
        err_mark = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        logic [`BMM_WORD_W-1:0] data;
        wb_read(`BMM_ADR_CTRL, data);
        check_word("ctrl", data, status_word(1'b0, 1'b0));
        for (int i = 0; i < `BMM_SIZE; i++) begin
            for (int j = 0; j < `BMM_SIZE; j++) begin
                c_exp[i][j] = '0;
            end
        end
        check_result();
        end_test("reset state");
    endtask

    task automatic test_readback();
        logic [`BMM_WORD_W-1:0] wdata [2 * `BMM_MAT_WORDS];
        logic [`BMM_WORD_W-1:0] data;
        // All words written before any read, so aliased words show up
        for (int w = 0; w < 2 * `BMM_MAT_WORDS; w++) begin
            wdata[w] = next_rand();
            wb_write(`BMM_ADR_A + w, wdata[w]);
        end
        for (int w = 0; w < 2 * `BMM_MAT_WORDS; w++) begin
            wb_read(`BMM_ADR_A + w, data);
            check_word($sformatf("word %0d", `BMM_ADR_A + w), data, wdata[w]);
        end
        // Gap between the B words and C
        wb_read(9, data);
        check_word("unmapped word 9", data, '0);
        end_test("register readback");
    endtask

    task automatic test_identity();
        fill_random();
        for (int i = 0; i < `BMM_SIZE; i++) begin
            for (int j = 0; j < `BMM_SIZE; j++) begin
                a_m[i][j]   = elem_t'(i == j);
                c_exp[i][j] = acc_t'(b_m[i][j]);
            end
        end
        load_matrices();
        start_product();
        wait_done();
        check_result();
        end_test("identity product");
    endtask

    task automatic test_max_values();
        for (int i = 0; i < `BMM_SIZE; i++) begin
            for (int j = 0; j < `BMM_SIZE; j++) begin
                a_m[i][j]   = 4'd15;
                b_m[i][j]   = 4'd15;
                c_exp[i][j] = 10'd900;
            end
        end
        load_matrices();
        start_product();
        wait_done();
        check_result();
        end_test("maximum values");
    endtask

    task automatic test_random_products();
        for (int n = 0; n < 3; n++) begin
            fill_random();
            compute_reference();
            load_matrices();
            start_product();
            wait_done();
            check_result();
        end
        end_test("random products");
    endtask

    task automatic test_busy_protection();
        logic [`BMM_WORD_W-1:0] orig;
        logic [`BMM_WORD_W-1:0] data;
        fill_random();
        compute_reference();
        load_matrices();
        wb_read(`BMM_ADR_A, orig);
        start_product();
        wb_write(`BMM_ADR_A, ~orig);
        start_product();
        wb_read(`BMM_ADR_CTRL, data);
        check_word("ctrl while busy", data, status_word(1'b1, 1'b0));
        wait_done();
        check_result();
        wb_read(`BMM_ADR_A, data);
        check_word("A word after busy write", data, orig);
        // A queued second start would drop done and raise busy again
        for (int n = 0; n < 20; n++) begin
            wb_read(`BMM_ADR_CTRL, data);
            check_word("ctrl after done", data, status_word(1'b0, 1'b1));
        end
        end_test("busy protection");
    endtask

    initial begin
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        @(posedge clk);
        #2;
        test_reset_state();
        test_readback();
        test_identity();
        test_max_values();
        test_random_products();
        test_busy_protection();
        $display("Tests: %0d, checks: %0d, errors: %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: bmm_top.f
+incdir+.
bmm_types_pkg.sv
bmm_bus_pkg.sv
bmm_ifs.sv
bmm_wb_regs.sv
bmm_matrix_store.sv
bmm_block_sched.sv
bmm_partial.sv
bmm_top.sv
bmm_assertions.sv
bmm_tb.sv

// File: bmm_top.sv
// Block matrix multiplier top level
// Wishbone classic slave in front of a matrix store, a block scheduler
// and a single block engine

`include "bmm_defines.svh"

module bmm_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`BMM_ADR_W-1:0]  wb_adr,
    input  logic [`BMM_WORD_W-1:0] wb_dat_w,
    output logic [`BMM_WORD_W-1:0] wb_dat_r,
    output logic                   wb_ack
);

    logic start;
    logic busy;
    logic done;

    store_if st_bus ();
    block_if blk_bus ();

    bmm_wb_regs u_wb_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .store    (st_bus),
        .busy     (busy),
        .done     (done),
        .start    (start)
    );

    bmm_matrix_store u_store (
        .clk (clk),
        .rst (rst),
        .acc (st_bus),
        .blk (blk_bus)
    );

    bmm_block_sched u_sched (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .busy  (busy),
        .done  (done),
        .blk   (blk_bus)
    );

    bmm_partial u_engine (
        .clk (clk),
        .rst (rst),
        .blk (blk_bus)
    );

endmodule

// File: bmm_types_pkg.sv
// Arithmetic types of the block multiplier
// Elements, results, operand bundles and partial result blocks

`include "bmm_defines.svh"

package bmm_types_pkg;

    // One unsigned matrix element
    typedef logic [`BMM_DATA_W-1:0] elem_t;

    // One result element wide enough for the largest dot product
    typedef logic [`BMM_ACC_W-1:0] acc_t;

    // BLOCK rows of A indexed by [i][k]
    typedef elem_t [`BMM_BLOCK-1:0][`BMM_SIZE-1:0] row_bundle_t;

    // BLOCK columns of B indexed by [k][j]
    typedef elem_t [`BMM_SIZE-1:0][`BMM_BLOCK-1:0] col_bundle_t;

    // One partial block of C indexed by [i][j]
    typedef acc_t [`BMM_BLOCK-1:0][`BMM_BLOCK-1:0] block_res_t;

    // Block position along one side of the matrix
    typedef logic [$clog2(`BMM_NBLK)-1:0] blk_idx_t;

    // Step along the shared dimension
    typedef logic [$clog2(`BMM_SIZE)-1:0] k_idx_t;

endpackage

// File: bmm_wb_regs.sv
// Wishbone classic slave of the block multiplier
// Decodes word addresses into regions, forwards matrix accesses to the
// store and owns the start, busy and done bits of the control word

`include "bmm_defines.svh"

module bmm_wb_regs import bmm_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`BMM_ADR_W-1:0]  wb_adr,
    input  logic [`BMM_WORD_W-1:0] wb_dat_w,
    output logic [`BMM_WORD_W-1:0] wb_dat_r,
    output logic                   wb_ack,
    store_if.host                  store,
    input  logic                   busy,
    input  logic                   done,
    output logic                   start
);

    reg_word_u  wr_word;
    reg_word_u  status_word;
    region_e    region;
    store_idx_t index;
    logic       access;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        region = NONE;
        index  = '0;
        if (wb_adr == `BMM_ADR_CTRL) begin
            region = CTRL;
        end else if (wb_adr >= `BMM_ADR_A && wb_adr < `BMM_ADR_A + `BMM_MAT_WORDS) begin
            region = MAT_A;
            index  = store_idx_t'(wb_adr - `BMM_ADR_A);
        end else if (wb_adr >= `BMM_ADR_B && wb_adr < `BMM_ADR_B + `BMM_MAT_WORDS) begin
            region = MAT_B;
            index  = store_idx_t'(wb_adr - `BMM_ADR_B);
        end else if (wb_adr >= `BMM_ADR_C) begin
            region = MAT_C;
            index  = store_idx_t'(wb_adr - `BMM_ADR_C);
        end
    end

    ////////////////////////////////////////////////////////////
    // Access cycle and store forwarding
    ////////////////////////////////////////////////////////////

    // First cycle of a strobe, the ack goes out on the next one
    assign access  = wb_cyc && wb_stb && !wb_ack;
    assign wr_word = wb_dat_w;

    assign store.wr     = access && wb_we;
    assign store.rd     = access && !wb_we;
    assign store.region = region;
    assign store.index  = index;
    assign store.wdata  = wr_word.elems;

    assign start = store.wr && (region == CTRL) && wr_word.ctrl.start;

    // Start always reads back as zero
    always_comb begin
        status_word           = '0;
        status_word.ctrl.busy = busy;
        status_word.ctrl.done = done;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    // Read data held for the ack cycle
    always_ff @(posedge clk) begin
        if (store.rd) begin
            if (region == CTRL) begin
                wb_dat_r <= status_word;
            end else begin
                wb_dat_r <= store.rdata;
            end
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the block multiplier testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module bmm_tb -f bmm_top.f \
    -o bmm_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/bmm_sim > sim.log 2>&1 || echo "Simulator exited with an error status"

grep -q "\*\* FAIL \*\*" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "\*\* PASS \*\*" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Simulation passed"
